// ==== coreState.sv ====
`timescale 1ns/10ps

module coreState (
	input logic CLK,
	input logic rstN,
	input logic stop,
	input logic regWe,
	input logic pcWe,
	input logic stepPulse,
	input logic [forthDebugPkg::regIdxWidth-1:0] idx,
	input logic [forthDebugPkg::wordWidth-1:0] wdata,
	output logic [forthDebugPkg::wordWidth-1:0] regBData,
	output logic [forthDebugPkg::wordWidth-1:0] ccData,
	output logic [forthDebugPkg::wordWidth-1:0] pcData
);
	import forthDebugPkg::*;

	logic [wordWidth-1:0] pc;
	logic [wordWidth-1:0] regFile [regCount];
	logic [hostWidth-1:0] stepCount; // High byte of cc.
	logic zeroFlag;
	logic negFlag;
	logic doStep;

	assign doStep = stepPulse || !stop; // Single step or free run.

	// Program counter and step count.
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			stepCount <= '0;
		end else begin
			if (pcWe) begin
				pc <= wdata; // Debug write wins.
			end else if (doStep) begin
				pc <= pc + 2'd2; // One word.
			end
			if (doStep) begin
				stepCount <= stepCount + 1'b1;
			end
		end
	end

	// Register file and flags of the last write.
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regFile[i] <= '0;
			end
			zeroFlag <= 1'b0;
			negFlag <= 1'b0;
		end else if (regWe) begin
			regFile[idx] <= wdata;
			zeroFlag <= (wdata == '0);
			negFlag <= wdata[wordWidth-1]; // Sign bit.
		end
	end

	assign regBData = regFile[idx];
	assign pcData = pc;

	// Step count, spare zeros, then the flags.
	always_comb begin
		ccData = '0;
		ccData[wordWidth-1:hostWidth] = stepCount;
		ccData[ccZeroBit] = zeroFlag;
		ccData[ccNegBit] = negFlag;
	end

endmodule

// ==== debugCtrlIf.sv ====
`timescale 1ns/10ps

interface debugCtrlIf;
	import forthDebugPkg::*;

	// Request side, from the port.
	debugOp op; // Operation code.
	logic inc; // Auto-increment or step select.
	logic [wordWidth-1:0] addr; // Word address, bit 0 zero.
	logic [memIdxWidth-1:0] argx; // Address bits 8 to 1.
	logic [wordWidth-1:0] wdata; // Host data word.
	logic req; // Level, held until ack.

	// Response side, from the sequencer.
	logic ack; // One-cycle pulse.
	logic ldData; // Capture the selected result.
	dataSel sel; // Result source.
	logic addrInc; // Bump the address by one word.

	modport port (
		output op, inc, addr, argx, wdata, req,
		input ack, ldData, sel, addrInc
	);

	modport seq (
		input op, inc, addr, argx, wdata, req,
		output ack, ldData, sel, addrInc
	);

endinterface

// ==== debugMemory.sv ====
`timescale 1ns/10ps

module debugMemory (
	input logic CLK,
	input logic we,
	input logic [forthDebugPkg::wordWidth-1:0] addr,
	input logic [forthDebugPkg::wordWidth-1:0] wdata,
	output logic [forthDebugPkg::wordWidth-1:0] rdata
);
	import forthDebugPkg::*;

	logic [wordWidth-1:0] mem [memDepth]; // Word array.
	logic [memIdxWidth-1:0] idx;

	assign idx = addr[memIdxWidth:1]; // Byte address to word index.

	// Write and registered read on the same edge.
	always_ff @(posedge CLK) begin
		if (we) begin
			mem[idx] <= wdata;
		end
		rdata <= mem[idx]; // Old data on a write cycle.
	end

endmodule

// ==== debugPort.sv ====
`timescale 1ns/10ps

module debugPort (
	input logic CLK,
	input logic rstN,
	input logic [forthDebugPkg::hostWidth-1:0] din,
	output logic [forthDebugPkg::hostWidth-1:0] dout,
	input forthDebugPkg::hostReg addr,
	input logic rdN,
	input logic wrN,
	output logic stop,
	output logic mode,
	debugCtrlIf.port ctrl,
	input logic [forthDebugPkg::wordWidth-1:0] memData,
	input logic [forthDebugPkg::wordWidth-1:0] regBData,
	input logic [forthDebugPkg::wordWidth-1:0] ccData,
	input logic [forthDebugPkg::wordWidth-1:0] pcData
);
	import forthDebugPkg::*;

	logic wrS1; // Strobe synchronizer.
	logic wrS2;
	logic wrPrev; // Edge history.
	logic wrRise; // Host write completes.
	logic [hostWidth-1:0] dinS1; // Bus data pipe.
	logic [hostWidth-1:0] dinS2;
	hostReg addrS1; // Bus address pipe.
	hostReg addrS2;
	logic fireNow; // This write starts an operation.
	logic fireQ; // Delays req by one cycle.
	logic [modeWidth-1:0] modeReg;
	logic [opRegWidth-1:0] opReg;
	logic [wordWidth-1:0] dataReg;
	logic [wordWidth-1:0] addrReg;
	logic [wordWidth-1:0] dataMux;
	logic [wordWidth-1:0] resultReg;

	// Strobe sampled in the CLK domain, idle high.
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			wrS1 <= 1'b1;
			wrS2 <= 1'b1;
			wrPrev <= 1'b1;
		end else begin
			wrS1 <= wrN;
			wrS2 <= wrS1;
			wrPrev <= wrS2;
		end
	end

	// Bus data and address travel alongside the strobe.
	always_ff @(posedge CLK) begin
		dinS1 <= din;
		dinS2 <= dinS1;
		addrS1 <= addr;
		addrS2 <= addrS1;
	end

	assign wrRise = wrS2 && !wrPrev; // Rising edge of wrN.

	// Mode write with the request bit, or streaming write to the high data byte.
	assign fireNow = wrRise && !ctrl.req && !fireQ &&
		((addrS2 == regMode && dinS2[modeReqBit]) ||
		(addrS2 == regDh && opReg[opIncBit]));

	// Host registers.
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			modeReg <= '0;
			opReg <= '0;
			dataReg <= '0;
			addrReg <= '0;
		end else begin
			if (ctrl.addrInc) begin
				addrReg[wordWidth-1:1] <= addrReg[wordWidth-1:1] + 1'b1; // Next word.
			end
			if (wrRise) begin
				case (addrS2)
					regMode: modeReg <= dinS2[modeWidth-1:0];
					regOp: opReg <= dinS2[opRegWidth-1:0];
					regDl: dataReg[hostWidth-1:0] <= dinS2;
					regDh: dataReg[wordWidth-1:hostWidth] <= dinS2;
					regAl: addrReg[hostWidth-1:1] <= dinS2[hostWidth-1:1]; // Bit 0 stays zero.
					regAh: addrReg[wordWidth-1:hostWidth] <= dinS2;
					default: ; // Reserved slots.
				endcase
			end
		end
	end

	// Request level, cleared by ack.
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			fireQ <= 1'b0;
			ctrl.req <= 1'b0;
		end else begin
			fireQ <= fireNow;
			if (ctrl.ack) begin
				ctrl.req <= 1'b0;
			end else if (fireQ) begin
				ctrl.req <= 1'b1;
			end
		end
	end

	assign ctrl.op = debugOp'(opReg[2:0]);
	assign ctrl.inc = opReg[opIncBit];
	assign ctrl.addr = addrReg;
	assign ctrl.argx = addrReg[memIdxWidth:1];
	assign ctrl.wdata = dataReg;

	// Data-select mux.
	always_comb begin
		case (ctrl.sel)
			selMem: dataMux = memData;
			selRegB: dataMux = regBData;
			selCc: dataMux = ccData;
			selPc: dataMux = pcData;
			default: dataMux = memData;
		endcase
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			resultReg <= '0;
		end else if (ctrl.ldData) begin
			resultReg <= dataMux; // Result of the finished operation.
		end
	end

	// Host read mux.
	always_comb begin
		if (rdN) begin
			dout = '0; // Bus idle.
		end else if (addr == regDh) begin
			dout = resultReg[wordWidth-1:hostWidth];
		end else begin
			dout = resultReg[hostWidth-1:0];
		end
	end

	assign stop = modeReg[modeStopBit];
	assign mode = modeReg[modeModeBit];

endmodule

// ==== debugSequencer.sv ====
`timescale 1ns/10ps

module debugSequencer (
	input logic CLK,
	input logic rstN,
	debugCtrlIf.seq ctrl,
	output logic memWe,
	output logic [forthDebugPkg::wordWidth-1:0] memAddr,
	output logic [forthDebugPkg::wordWidth-1:0] memWdata,
	output logic regWe,
	output logic pcWe,
	output logic stepPulse,
	output logic [forthDebugPkg::regIdxWidth-1:0] coreIdx,
	output logic [forthDebugPkg::wordWidth-1:0] coreWdata
);
	import forthDebugPkg::*;

	// Two cycles from req to ack.
	typedef enum logic [1:0] {
		idle,
		access,
		done
	} seqState;

	seqState state;
	seqState nextState;
	logic isMemOp; // Read or write of memory.
	logic isPcSlot; // Write pc or step.

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= idle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		case (state)
			idle: nextState = ctrl.req ? access : idle;
			access: nextState = done;
			done: nextState = idle; // req drops on the same edge.
			default: nextState = idle;
		endcase
	end

	assign isMemOp = (ctrl.op == opReadMem) || (ctrl.op == opWriteMem);
	assign isPcSlot = (ctrl.op == opWritePc);

	// One strobe per operation, in access only.
	assign memWe = (state == access) && (ctrl.op == opWriteMem);
	assign regWe = (state == access) && (ctrl.op == opWriteReg);
	assign pcWe = (state == access) && isPcSlot && !ctrl.inc;
	assign stepPulse = (state == access) && isPcSlot && ctrl.inc; // opStep.

	assign memAddr = ctrl.addr;
	assign memWdata = ctrl.wdata;
	assign coreIdx = ctrl.argx[regIdxWidth-1:0]; // Register index.
	assign coreWdata = ctrl.wdata;

	// Result source by op.
	always_comb begin
		case (ctrl.op)
			opReadMem, opWriteMem: ctrl.sel = selMem;
			opReadReg, opWriteReg: ctrl.sel = selRegB;
			opReadCc: ctrl.sel = selCc;
			opReadPc, opWritePc: ctrl.sel = selPc;
			default: ctrl.sel = selMem; // Nop.
		endcase
	end

	assign ctrl.ack = (state == done);
	assign ctrl.ldData = (state == done);
	assign ctrl.addrInc = (state == done) && isMemOp && ctrl.inc;

endmodule

// ==== forthDebug.f ====
forthDebugPkg.sv
debugCtrlIf.sv
debugPort.sv
debugSequencer.sv
debugMemory.sv
coreState.sv
forthDebugTop.sv
forthDebug_checker.sv
forthDebugTb.sv

// ==== forthDebugPkg.sv ====
package forthDebugPkg;

	// Datapath widths.
	localparam int wordWidth = 16; // CPU word.
	localparam int hostWidth = 8; // Host bus byte.

	// Memory and register file sizes.
	localparam int memDepth = 256;
	localparam int memIdxWidth = $clog2(memDepth); // Word index, address bits 8 to 1.
	localparam int regCount = 8;
	localparam int regIdxWidth = $clog2(regCount);

	// Op register layout.
	localparam int opRegWidth = 4;
	localparam int opIncBit = 3; // Auto-increment, or step select.

	// Mode register layout and the request bit of a mode write.
	localparam int modeWidth = 2;
	localparam int modeModeBit = 0;
	localparam int modeStopBit = 1;
	localparam int modeReqBit = 2; // Only in din, never stored.

	// Condition code flags of the last register write.
	localparam int ccZeroBit = 0;
	localparam int ccNegBit = 1;

	// Host register select.
	typedef enum logic [2:0] {
		regMode = 3'd0,
		regOp = 3'd1,
		regDl = 3'd2,
		regDh = 3'd3,
		regAl = 3'd4,
		regAh = 3'd5,
		regRsv0 = 3'd6,
		regRsv1 = 3'd7
	} hostReg;

	// Debug operations.
	typedef enum logic [2:0] {
		opNop = 3'd0,
		opReadMem = 3'd1,
		opWriteMem = 3'd2,
		opReadReg = 3'd3,
		opWriteReg = 3'd4,
		opReadCc = 3'd5,
		opReadPc = 3'd6,
		opWritePc = 3'd7 // Step when opIncBit is set.
	} debugOp;

	localparam debugOp opStep = opWritePc; // Same slot as opWritePc.

	// Result source of the data-select mux.
	typedef enum logic [1:0] {
		selMem = 2'd0,
		selRegB = 2'd1,
		selCc = 2'd2,
		selPc = 2'd3
	} dataSel;

endpackage

// ==== forthDebugTb.sv ====
`timescale 1ns/10ps

module forthDebugTb;
	import forthDebugPkg::*;

	localparam int memWords = 6;
	localparam int streamWords = 8;
	localparam int stepRuns = 5;
	localparam int opBudget = 60; // Setup writes, fire, wait and two reads.
	localparam int firedOps = 2 * memWords + 2 * streamWords + 2 * regCount + stepRuns + 9;
	localparam int cycleLimit = firedOps * opBudget + 200;

	logic CLK;
	logic rstN;
	logic [hostWidth-1:0] din;
	logic [hostWidth-1:0] dout;
	hostReg hostAddr;
	logic rdN;
	logic wrN;
	logic stop;
	logic mode;

	// Reference model.
	logic [wordWidth-1:0] modelMem [memDepth];
	logic [wordWidth-1:0] modelReg [regCount];
	logic [wordWidth-1:0] modelPc;
	logic [hostWidth-1:0] modelSteps; // Step count, high byte of cc.
	logic modelZero;
	logic modelNeg;

	string nameQ [$]; // Pending comparisons.
	logic [wordWidth-1:0] expQ [$];
	logic [wordWidth-1:0] actQ [$];
	event resultReady;
	integer seed;
	int valueErrors;
	int otherErrors;
	int checkCount;
	int cycles;

	forthDebugTop UUT (
		.CLK(CLK),
		.rstN(rstN),
		.din(din),
		.dout(dout),
		.addr(hostAddr),
		.rdN(rdN),
		.wrN(wrN),
		.stop(stop),
		.mode(mode)
	);

	bind debugSequencer forthDebug_checker seqChecker (
		.CLK(CLK),
		.rstN(rstN),
		.req(ctrl.req),
		.ack(ctrl.ack),
		.ldData(ctrl.ldData),
		.addrInc(ctrl.addrInc)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// Expected result word of an operation.
	function automatic logic [wordWidth-1:0] expectResult(debugOp op, logic [memIdxWidth-1:0] idx);
		case (op)
			opReadMem, opWriteMem: return modelMem[idx];
			opReadReg, opWriteReg: return modelReg[idx[regIdxWidth-1:0]];
			opReadCc: return {modelSteps, 6'b0, modelNeg, modelZero};
			default: return modelPc;
		endcase
	endfunction

	task automatic checkValue(string name, logic [wordWidth-1:0] expected,
			logic [wordWidth-1:0] actual);
		checkCount++;
		if (actual !== expected) begin
			valueErrors++;
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic queueCheck(string name, logic [wordWidth-1:0] expected,
			logic [wordWidth-1:0] actual);
		nameQ.push_back(name);
		expQ.push_back(expected);
		actQ.push_back(actual);
		-> resultReady;
	endtask

	// Comparing process.
	initial begin
		forever begin
			@(resultReady);
			while (expQ.size() > 0) begin
				checkValue(nameQ.pop_front(), expQ.pop_front(), actQ.pop_front());
			end
		end
	end

	// Strobe low for two cycles; data held well past the rising edge.
	task automatic hostWrite(hostReg target, logic [hostWidth-1:0] data, bit fires);
		@(posedge CLK);
		hostAddr <= target;
		din <= data;
		wrN <= 1'b0;
		repeat (2) @(posedge CLK);
		wrN <= 1'b1;
		repeat (fires ? 10 : 4) @(posedge CLK); // 10 covers the 7-cycle latency.
	endtask

	task automatic hostRead(hostReg target, output logic [hostWidth-1:0] data);
		@(posedge CLK);
		hostAddr <= target;
		rdN <= 1'b0;
		@(negedge CLK);
		data = dout; // Settled mid-cycle.
		@(posedge CLK);
		rdN <= 1'b1;
	endtask

	task automatic readWord(output logic [wordWidth-1:0] word);
		logic [hostWidth-1:0] lo;
		logic [hostWidth-1:0] hi;
		hostRead(regDl, lo);
		hostRead(regDh, hi);
		word = {hi, lo};
	endtask

	task automatic setWordAddr(logic [wordWidth-1:0] byteAddr);
		hostWrite(regAl, byteAddr[hostWidth-1:0], 1'b0);
		hostWrite(regAh, byteAddr[wordWidth-1:hostWidth], 1'b0);
	endtask

	task automatic setData(logic [wordWidth-1:0] word);
		hostWrite(regDl, word[hostWidth-1:0], 1'b0);
		hostWrite(regDh, word[wordWidth-1:hostWidth], 1'b0);
	endtask

	// Load op, then mode write with the request bit and stop kept high.
	task automatic fireOp(debugOp op, bit inc);
		hostWrite(regOp, {4'b0, inc, op}, 1'b0);
		hostWrite(regMode, 8'h06, 1'b1);
	endtask

	task automatic readCheck(string name, debugOp op, logic [memIdxWidth-1:0] idx);
		logic [wordWidth-1:0] got;
		fireOp(op, 1'b0);
		readWord(got);
		queueCheck(name, expectResult(op, idx), got);
	endtask

	initial begin
		logic [wordWidth-1:0] got;
		logic [wordWidth-1:0] value;
		logic [memIdxWidth-1:0] idx;
		logic [memIdxWidth-1:0] slot;
		logic [memIdxWidth-1:0] idxList [memWords];
		logic [wordWidth-1:0] pcDelta;

		seed = 62547;
		valueErrors = 0;
		otherErrors = 0;
		checkCount = 0;
		rstN = 1'b0;
		din = '0;
		hostAddr = regMode;
		rdN = 1'b1;
		wrN = 1'b1;
		repeat (2) @(posedge CLK);
		rstN <= 1'b1;

		@(negedge CLK);
		queueCheck("stop", 16'd0, {15'd0, stop});
		queueCheck("mode", 16'd0, {15'd0, mode});
		readWord(got);
		queueCheck("dout after reset", 16'h0000, got);

		// Halt the core with the mode bit set; the step count so far is the baseline.
		hostWrite(regMode, 8'h03, 1'b0);
		queueCheck("stop", 16'd1, {15'd0, stop});
		queueCheck("mode", 16'd1, {15'd0, mode});
		fireOp(opReadCc, 1'b0);
		readWord(got);
		queueCheck("cc flags", 16'h0000, {8'h00, got[hostWidth-1:0]});
		modelSteps = got[wordWidth-1:hostWidth];
		modelZero = 1'b0;
		modelNeg = 1'b0;

		// Random memory writes, then readback.
		for (int i = 0; i < memWords; i++) begin
			idx = $random(seed);
			value = $random(seed);
			idxList[i] = idx;
			modelMem[idx] = value;
			setWordAddr({7'd0, idx, 1'b0});
			setData(value);
			fireOp(opWriteMem, 1'b0);
		end
		for (int i = 0; i < memWords; i++) begin
			setWordAddr({7'd0, idxList[i], 1'b0});
			readCheck("memory word", opReadMem, idxList[i]);
		end

		// Streaming through regDh with auto-increment.
		idx = $random(seed);
		hostWrite(regOp, {4'b0, 1'b1, opWriteMem}, 1'b0);
		setWordAddr({7'd0, idx, 1'b0});
		for (int i = 0; i < streamWords; i++) begin
			value = $random(seed);
			slot = idx + memIdxWidth'(i); // Wraps like the word index.
			modelMem[slot] = value;
			hostWrite(regDl, value[hostWidth-1:0], 1'b0);
			hostWrite(regDh, value[wordWidth-1:hostWidth], 1'b1);
		end
		for (int i = 0; i < streamWords; i++) begin
			slot = idx + memIdxWidth'(i);
			setWordAddr({7'd0, slot, 1'b0});
			readCheck("streamed word", opReadMem, slot);
		end

		// Register file, last write to index 0 is zero.
		for (int i = regCount - 1; i >= 0; i--) begin
			if (i == 0) begin
				value = '0;
			end else if (i == 1) begin
				value = 16'h8000 | $random(seed); // Negative.
			end else begin
				value = $random(seed);
			end
			modelReg[i] = value;
			modelZero = (value == '0);
			modelNeg = value[wordWidth-1];
			setWordAddr(16'(i * 2));
			setData(value);
			fireOp(opWriteReg, 1'b0);
		end
		for (int i = 0; i < regCount; i++) begin
			setWordAddr(16'(i * 2));
			readCheck("register", opReadReg, memIdxWidth'(i));
		end
		readCheck("cc zero flag", opReadCc, '0);
		setWordAddr(16'd2);
		setData(modelReg[1]);
		fireOp(opWriteReg, 1'b0);
		modelZero = (modelReg[1] == '0);
		modelNeg = modelReg[1][wordWidth-1];
		readCheck("cc negative flag", opReadCc, '0);

		// Write pc, then single steps.
		value = $random(seed) & 16'hFFFE;
		setData(value);
		fireOp(opWritePc, 1'b0);
		modelPc = value;
		for (int i = 0; i < stepRuns; i++) begin
			fireOp(opStep, 1'b1);
			modelPc = modelPc + 16'd2;
			modelSteps = modelSteps + 8'd1;
		end
		readCheck("pc after steps", opReadPc, '0);
		readCheck("cc after steps", opReadCc, '0);

		// Free run for a while.
		hostWrite(regMode, 8'h00, 1'b0);
		repeat (6) @(posedge CLK);
		hostWrite(regMode, 8'h02, 1'b0);
		fireOp(opReadPc, 1'b0);
		readWord(got);
		pcDelta = got - modelPc;
		if (pcDelta == '0 || pcDelta[0]) begin
			otherErrors++;
			$display("Free run went wrong: pc moved by %0d, not an even nonzero amount", pcDelta);
		end
		fireOp(opReadCc, 1'b0);
		readWord(got);
		queueCheck("cc after free run", {modelSteps + pcDelta[8:1], 6'b0, modelNeg, modelZero}, got);

		repeat (2) @(posedge CLK);
		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			checkCount, valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// Watchdog.
	initial begin
		cycles = 0;
		while (cycles < cycleLimit) begin
			@(posedge CLK);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== forthDebugTop.sv ====
`timescale 1ns/10ps

module forthDebugTop (
	input logic CLK,
	input logic rstN,
	input logic [forthDebugPkg::hostWidth-1:0] din,
	output logic [forthDebugPkg::hostWidth-1:0] dout,
	input forthDebugPkg::hostReg addr,
	input logic rdN,
	input logic wrN,
	output logic stop,
	output logic mode
);
	import forthDebugPkg::*;

	debugCtrlIf ctrl (); // Port to sequencer.

	logic [wordWidth-1:0] memData; // Memory read word.
	logic [wordWidth-1:0] regBData;
	logic [wordWidth-1:0] ccData;
	logic [wordWidth-1:0] pcData;
	logic memWe;
	logic [wordWidth-1:0] memAddr;
	logic [wordWidth-1:0] memWdata;
	logic regWe;
	logic pcWe;
	logic stepPulse;
	logic [regIdxWidth-1:0] coreIdx;
	logic [wordWidth-1:0] coreWdata;

	debugPort dbgPort (
		.CLK(CLK),
		.rstN(rstN),
		.din(din),
		.dout(dout),
		.addr(addr),
		.rdN(rdN),
		.wrN(wrN),
		.stop(stop),
		.mode(mode),
		.ctrl(ctrl.port),
		.memData(memData),
		.regBData(regBData),
		.ccData(ccData),
		.pcData(pcData)
	);

	debugSequencer dbgSeq (
		.CLK(CLK),
		.rstN(rstN),
		.ctrl(ctrl.seq),
		.memWe(memWe),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.regWe(regWe),
		.pcWe(pcWe),
		.stepPulse(stepPulse),
		.coreIdx(coreIdx),
		.coreWdata(coreWdata)
	);

	debugMemory dbgMem (
		.CLK(CLK),
		.we(memWe),
		.addr(memAddr),
		.wdata(memWdata),
		.rdata(memData)
	);

	coreState core (
		.CLK(CLK),
		.rstN(rstN),
		.stop(stop), // Free runs while low.
		.regWe(regWe),
		.pcWe(pcWe),
		.stepPulse(stepPulse),
		.idx(coreIdx),
		.wdata(coreWdata),
		.regBData(regBData),
		.ccData(ccData),
		.pcData(pcData)
	);

endmodule

// ==== forthDebug_checker.sv ====
`timescale 1ns/10ps

module forthDebug_checker (
	input logic CLK,
	input logic rstN,
	input logic req,
	input logic ack,
	input logic ldData,
	input logic addrInc
);

	// Ack two cycles after req rises.
	property ackLatency;
		@(posedge CLK) disable iff (!rstN)
		$rose(req) |-> !ack ##1 !ack ##1 ack;
	endproperty

	property ackSingle;
		@(posedge CLK) disable iff (!rstN)
		ack |=> (!ack && !req); // One-cycle pulse and req released.
	endproperty

	// Capture and increment only while the request is still held.
	property pulsesWithAck;
		@(posedge CLK) disable iff (!rstN)
		(ldData || addrInc) |-> (ack && req);
	endproperty

	property quietInReset;
		@(posedge CLK) !rstN |-> (!req && !ack);
	endproperty

	ackLatencyA: assert property (ackLatency) else $error("ack did not follow req by two cycles");
	ackSingleA: assert property (ackSingle) else $error("ack stayed high for more than one cycle");
	pulsesWithAckA: assert property (pulsesWithAck) else $error("ldData or addrInc without ack");
	quietInResetA: assert property (quietInReset) else $error("req or ack high during reset");

endmodule
